// ==== include/lab_macros.svh ====
`ifndef LAB_MACROS_SVH
`define LAB_MACROS_SVH

// clk cycles per tick
// a board build sets this to the clock rate in Hz for a one second tick
`define TICK_DIV 10

// seven-segment digits on the board
`define SEG_DIGITS 8

`endif

// ==== src/lab_pkg.sv ====
package lab_pkg;

    typedef logic [3:0] nibble_t;   // alu operand or result
    typedef logic [3:0] digit_t;    // one bcd digit
    typedef logic [7:0] seg_t;      // active low segments with dp on bit 7
    typedef logic [2:0] code3_t;
    typedef logic [7:0] onehot8_t;
    typedef logic [7:0] byte_t;
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_NOT = 3'd2;
    localparam alu_op_t ALU_AND = 3'd3;
    localparam alu_op_t ALU_OR  = 3'd4;
    localparam alu_op_t ALU_XOR = 3'd5;
    localparam alu_op_t ALU_LT  = 3'd6;  // signed compare
    localparam alu_op_t ALU_EQ  = 3'd7;

    typedef struct packed {
        logic zero;
        logic overflow;
        logic carry;
    } alu_flags_t;

    typedef struct packed {
        digit_t tens;
        digit_t ones;
    } bcd_count_t;

    // d0 is the rightmost digit
    typedef struct packed {
        seg_t d7;
        seg_t d6;
        seg_t d5;
        seg_t d4;
        seg_t d3;
        seg_t d2;
        seg_t d1;
        seg_t d0;
    } seg_bank_t;

endpackage

// ==== src/tick_timer.sv ====
`timescale 1ns/1ns
`include "lab_macros.svh"

module tick_timer (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = $clog2(`TICK_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_LAST);

    // free running divider, the tick lands one cycle after the wrap is seen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;  // single cycle pulse
        end
    end

endmodule

// ==== src/tick_counters.sv ====
`timescale 1ns/1ns

module tick_counters (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tick,
    input  logic                count_en,
    output lab_pkg::bcd_count_t count,
    output lab_pkg::code3_t     down_count
);

    import lab_pkg::*;

    logic   step;
    digit_t ones_nxt;
    digit_t tens_nxt;

    assign step = tick && count_en;

    // decimal increment kept in bcd, 99 rolls over to 00
    always_comb begin
        ones_nxt = count.ones + 4'd1;
        tens_nxt = count.tens;
        if (count.ones >= 4'd9) begin
            ones_nxt = '0;
            if (count.tens >= 4'd9) begin
                tens_nxt = '0;
            end else begin
                tens_nxt = count.tens + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count      <= '0;
            down_count <= '0;
        end else if (step) begin
            count.ones <= ones_nxt;
            count.tens <= tens_nxt;
            down_count <= down_count - 3'd1;  // 0 wraps to 7
        end
    end

endmodule

// ==== src/seg_driver.sv ====
`timescale 1ns/1ns
`include "lab_macros.svh"

module seg_driver (
    input  logic                clk,
    input  logic                rst_n,
    input  lab_pkg::bcd_count_t count,
    output lab_pkg::seg_bank_t  segs
);

    import lab_pkg::*;

    localparam seg_t SEG_BLANK = 8'hff;

    seg_t [`SEG_DIGITS-1:0] seg_nxt;

    // segment order is {dp, g, f, e, d, c, b, a}, low means lit
    function automatic seg_t bcd_to_seg(input digit_t d);
        seg_t pat;
        case (d)
            4'd0:    pat = 8'hc0;
            4'd1:    pat = 8'hf9;
            4'd2:    pat = 8'ha4;
            4'd3:    pat = 8'hb0;
            4'd4:    pat = 8'h99;
            4'd5:    pat = 8'h92;
            4'd6:    pat = 8'h82;
            4'd7:    pat = 8'hf8;
            4'd8:    pat = 8'h80;
            4'd9:    pat = 8'h90;
            default: pat = SEG_BLANK;  // not a bcd digit
        endcase
        return pat;
    endfunction

    always_comb begin
        for (int i = 0; i < `SEG_DIGITS; i++) begin
            seg_nxt[i] = SEG_BLANK;
        end
        seg_nxt[0] = bcd_to_seg(count.ones);
        seg_nxt[1] = bcd_to_seg(count.tens);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            segs    <= '1;
            segs.d0 <= bcd_to_seg(4'd0);  // shows 00
            segs.d1 <= bcd_to_seg(4'd0);
        end else begin
            segs <= seg_bank_t'(seg_nxt);
        end
    end

endmodule

// ==== src/alu_4bit.sv ====
`timescale 1ns/1ns

module alu_4bit (
    input  lab_pkg::alu_op_t    alu_op,
    input  lab_pkg::nibble_t    alu_a,
    input  lab_pkg::nibble_t    alu_b,
    output lab_pkg::nibble_t    alu_res,
    output lab_pkg::alu_flags_t alu_flags
);

    import lab_pkg::*;

    logic       is_sub;
    nibble_t    b_eff;
    logic [4:0] sum;      // bit 4 is the carry out
    logic       sum_ovf;

    // one adder for both, subtract is a + ~b + 1
    assign is_sub = (alu_op == ALU_SUB);
    assign b_eff  = is_sub ? ~alu_b : alu_b;
    assign sum    = {1'b0, alu_a} + {1'b0, b_eff} + {4'd0, is_sub};

    // operands of equal sign giving a result of the other sign
    assign sum_ovf = (alu_a[3] == b_eff[3]) && (sum[3] != alu_a[3]);

    always_comb begin
        alu_res            = '0;
        alu_flags.carry    = 1'b0;
        alu_flags.overflow = 1'b0;
        case (alu_op)
            ALU_ADD, ALU_SUB: begin
                alu_res            = sum[3:0];
                alu_flags.carry    = sum[4];
                alu_flags.overflow = sum_ovf;
            end
            ALU_NOT: alu_res = ~alu_a;
            ALU_AND: alu_res = alu_a & alu_b;
            ALU_OR:  alu_res = alu_a | alu_b;
            ALU_XOR: alu_res = alu_a ^ alu_b;
            ALU_LT: begin
                alu_res = {3'b000, ($signed(alu_a) < $signed(alu_b))};
            end
            ALU_EQ: begin
                alu_res = {3'b000, (alu_a == alu_b)};
            end
            default: alu_res = '0;
        endcase
        alu_flags.zero = (alu_res == 4'd0);  // for every op
    end

endmodule

// ==== src/select_logic.sv ====
`timescale 1ns/1ns

module select_logic (
    input  lab_pkg::byte_t    mux_in,
    input  logic [1:0]        mux_sel,
    output logic [1:0]        mux_out,
    input  lab_pkg::code3_t   dec_in,
    input  logic              dec_en,
    output lab_pkg::onehot8_t dec_out,
    input  lab_pkg::onehot8_t enc_in,
    input  logic              enc_en,
    output lab_pkg::code3_t   enc_out,
    output logic              enc_valid
);

    import lab_pkg::*;

    code3_t hi_idx;

    // field n sits at bits 2n+1:2n
    assign mux_out = mux_in[{mux_sel, 1'b0} +: 2];

    assign dec_out = dec_en ? onehot8_t'(8'd1 << dec_in) : '0;

    // scan upward so the highest request wins
    always_comb begin
        hi_idx = '0;
        for (int i = 0; i < 8; i++) begin
            if (enc_in[i]) begin
                hi_idx = code3_t'(i);
            end
        end
    end

    assign enc_valid = enc_en && (enc_in != '0);
    assign enc_out   = enc_valid ? hi_idx : '0;  // zero when idle or disabled

endmodule

// ==== src/lab_top.sv ====
`timescale 1ns/1ns

module lab_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                count_en,
    output logic                tick,
    output lab_pkg::code3_t     down_count,
    output lab_pkg::seg_bank_t  segs,
    input  lab_pkg::alu_op_t    alu_op,
    input  lab_pkg::nibble_t    alu_a,
    input  lab_pkg::nibble_t    alu_b,
    output lab_pkg::nibble_t    alu_res,
    output lab_pkg::alu_flags_t alu_flags,
    input  lab_pkg::byte_t      mux_in,
    input  logic [1:0]          mux_sel,
    output logic [1:0]          mux_out,
    input  lab_pkg::code3_t     dec_in,
    input  logic                dec_en,
    output lab_pkg::onehot8_t   dec_out,
    input  lab_pkg::onehot8_t   enc_in,
    input  logic                enc_en,
    output lab_pkg::code3_t     enc_out,
    output logic                enc_valid
);

    import lab_pkg::*;

    bcd_count_t count;  // decimal count toward the display

    tick_timer i_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    // count_en gates the counters only
    tick_counters i_counters (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .count_en   (count_en),
        .count      (count),
        .down_count (down_count)
    );

    seg_driver i_seg (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count),
        .segs  (segs)
    );

    alu_4bit i_alu (
        .alu_op    (alu_op),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_res   (alu_res),
        .alu_flags (alu_flags)
    );

    select_logic i_select (
        .mux_in    (mux_in),
        .mux_sel   (mux_sel),
        .mux_out   (mux_out),
        .dec_in    (dec_in),
        .dec_en    (dec_en),
        .dec_out   (dec_out),
        .enc_in    (enc_in),
        .enc_en    (enc_en),
        .enc_out   (enc_out),
        .enc_valid (enc_valid)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

// ==== verif/lab_asserts.sv ====
`timescale 1ns/1ns

module lab_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                tick,
    input logic                count_en,
    input lab_pkg::bcd_count_t count,
    input lab_pkg::code3_t     down_count
);

    // tick comes straight from the timer, so this covers the divider too
    tick_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick)
        else $error("tick stayed high for two cycles");

    digits_bcd: assert property (@(posedge clk) disable iff (!rst_n)
        count.ones <= 4'd9 && count.tens <= 4'd9)
        else $error("count digit above 9");

    count_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !(tick && count_en) |=> $stable(count) && $stable(down_count))
        else $error("counters moved without an enabled tick");

    zero_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> count == '0 && down_count == '0)
        else $error("counters not zero after reset");

endmodule

bind tick_counters lab_asserts i_asserts (.*);

// ==== verif/lab_tb.sv ====
`timescale 1ns/1ns
`include "lab_macros.svh"

module lab_tb;

    import lab_pkg::*;

    localparam int MAX_VEC = 64;

    logic clk, rst_n, count_en, tick, dec_en, enc_en, enc_valid;
    code3_t down_count, dec_in, enc_out;
    seg_bank_t segs;
    alu_op_t alu_op;
    nibble_t alu_a, alu_b, alu_res;
    alu_flags_t alu_flags;
    byte_t mux_in;
    logic [1:0] mux_sel, mux_out;
    onehot8_t dec_out, enc_in;

    int errors = 0;
    int test_errors = 0;
    int tests = 0;
    int failed_tests = 0;
    integer seed = 96;
    int model_cnt = 0;  // decimal count register
    int model_down = 0;
    bit adv = 1'b0;     // enabled tick seen last cycle

    tb_clock i_clock (.clk(clk), .rst_n(rst_n));

    lab_top i_dut (.*);

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic report(input string what, input logic [63:0] exp, input logic [63:0] act);
        errors++;
        test_errors++;
        $display("Mismatch at %0t ns: %s expected %h got %h", $time, what, exp, act);
    endtask

    task automatic check_nibble(input string what, input nibble_t exp, input nibble_t act);
        if (exp !== act) report(what, exp, act);
    endtask

    task automatic check_flags(input string what, input alu_flags_t exp, input alu_flags_t act);
        if (exp !== act) report(what, exp, act);
    endtask

    task automatic check_code3(input string what, input code3_t exp, input code3_t act);
        if (exp !== act) report(what, exp, act);
    endtask

    task automatic check_onehot8(input string what, input onehot8_t exp, input onehot8_t act);
        if (exp !== act) report(what, exp, act);
    endtask

    task automatic check_seg_bank(input string what, input seg_bank_t exp, input seg_bank_t act);
        if (exp !== act) report(what, exp, act);
    endtask

    task automatic check_tick_period(input string what, input int exp, input int act);
        if (exp != act) report(what, exp, act);
    endtask

    // standard common-anode codes, {dp, g..a}
    function automatic seg_t digit_pattern(input int d);
        seg_t table_pat[10] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,
                                8'h92, 8'h82, 8'hf8, 8'h80, 8'h90};
        return table_pat[d];
    endfunction

    function automatic seg_bank_t display_of(input int value);
        return {{6{8'hff}}, digit_pattern(value / 10), digit_pattern(value % 10)};
    endfunction

    task automatic tick_period_test();
        int cycles;
        int last;
        int seen;
        bit prev;
        cycles = 0;
        last = 0;
        seen = 0;
        prev = 1'b0;
        while (seen < 4) begin
            step();
            cycles++;
            if (tick && prev) begin
                errors++;
                test_errors++;
                $display("error at %0t ns: tick was high for two cycles", $time);
            end
            if (tick) begin
                check_tick_period("tick period", `TICK_DIV, cycles - last);
                last = cycles;
                seen++;
            end
            prev = tick;
        end
    endtask

    task automatic vector_test();
        int fd, n, nvec;
        int f[10];
        string line;
        fd = $fopen("verif/lab_input.txt", "r");
        nvec = 0;
        if (fd == 0) begin
            errors++;
            test_errors++;
            $display("error: cannot open verif/lab_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() == 0) continue;
            if (line.getc(0) == "A") begin
                n = $sscanf(line, "A %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                alu_op = alu_op_t'(f[0]);
                alu_a  = nibble_t'(f[1]);
                alu_b  = nibble_t'(f[2]);
                #40;
                check_nibble("alu_res", nibble_t'(f[3]), alu_res);
                check_flags("alu_flags", alu_flags_t'({f[4][0], f[5][0], f[6][0]}), alu_flags);
                nvec++;
                step();
            end else if (line.getc(0) == "S") begin
                n = $sscanf(line, "S %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                mux_in  = byte_t'(f[0]);
                mux_sel = 2'(f[1]);
                dec_in  = code3_t'(f[3]);
                dec_en  = f[4][0];
                enc_in  = onehot8_t'(f[6]);
                enc_en  = f[7][0];
                #40;
                check_code3("mux_out", code3_t'(f[2]), {1'b0, mux_out});
                check_onehot8("dec_out", onehot8_t'(f[5]), dec_out);
                check_code3("enc_out", code3_t'(f[8]), enc_out);
                check_code3("enc_valid", code3_t'(f[9]), {2'b00, enc_valid});
                nvec++;
                step();
            end
        end
        $fclose(fd);
        if (nvec == 0) begin
            errors++;
            test_errors++;
            $display("error: no vectors found in verif/lab_input.txt");
        end
    endtask

    // cycle model of the counters and display register
    task automatic counting_test(input int n_ticks, input bit random_en);
        int ticks;
        int pend;
        int seg_val;
        ticks = 0;
        pend = 0;
        while (ticks < n_ticks || pend != 0) begin
            step();
            seg_val = model_cnt;
            if (adv) begin
                model_cnt  = (model_cnt + 1) % 100;
                model_down = (model_down + 7) % 8;
            end
            adv = 1'b0;
            if (pend > 0) begin
                pend--;
                if (pend == 0) begin
                    check_seg_bank("segs", display_of(seg_val), segs);
                    check_code3("down_count", code3_t'(model_down), down_count);
                end
            end
            if (tick && ticks < n_ticks) begin
                ticks++;
                count_en = random_en ? 1'($random(seed)) : 1'b1;
                adv = count_en;
                pend = 2;
            end
        end
    endtask

    initial begin
        count_en = 1'b0;
        alu_op = '0;
        alu_a = '0;
        alu_b = '0;
        mux_in = '0;
        mux_sel = '0;
        dec_in = '0;
        dec_en = 1'b0;
        enc_in = '0;
        enc_en = 1'b0;

        wait (rst_n === 1'b1);
        check_code3("tick", 3'b000, {2'b00, tick});
        check_code3("down_count", 3'd0, down_count);
        check_seg_bank("segs", display_of(0), segs);
        end_test("reset");

        tick_period_test();
        end_test("tick period");

        vector_test();
        end_test("alu and select vectors");

        counting_test(105, 1'b0);
        end_test("counting and wrap");

        counting_test(40, 1'b1);
        end_test("enable gating");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #((MAX_VEC + 250 * `TICK_DIV) * 100 + 20000);
        $display("timeout: the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== verif/lab_input.txt ====
# A op a b res zero overflow carry                      (hex)
# S mux_in sel mux_out dec_in dec_en dec_out enc_in enc_en enc_out enc_valid
A 0 7 9 0 1 0 1
A 0 3 4 7 0 0 0
A 0 5 5 a 0 1 0
A 0 8 8 0 1 1 1
A 1 5 3 2 0 0 1
A 1 3 5 e 0 0 0
A 1 8 1 7 0 1 1
A 1 6 6 0 1 0 1
A 2 5 0 a 0 0 0
A 2 f 3 0 1 0 0
A 3 c a 8 0 0 0
A 4 5 2 7 0 0 0
A 5 9 9 0 1 0 0
A 6 d 2 1 0 0 0
A 6 2 f 0 1 0 0
A 6 8 f 1 0 0 0
A 7 a a 1 0 0 0
A 7 a b 0 1 0 0
S e4 0 0 3 1 08 52 1 6 1
S e4 1 1 0 1 01 00 1 0 0
S e4 2 2 7 0 00 ff 1 7 1
S e4 3 3 5 1 20 81 0 0 0
S 1b 2 1 2 1 04 0c 1 3 1
S 1b 0 3 6 1 40 01 1 0 1

// ==== sim.f ====
+incdir+include
src/lab_pkg.sv
src/tick_timer.sv
src/tick_counters.sv
src/seg_driver.sv
src/alu_4bit.sv
src/select_logic.sv
src/lab_top.sv
verif/tb_clock.sv
verif/lab_asserts.sv
verif/lab_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module lab_tb

sim:
	verilator --binary --timing --assert -f sim.f --top-module lab_tb -o lab_sim
	./obj_dir/lab_sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
